//--- verilog/desc_fetch_pkg.sv
// descriptor fetch engine shared definitions
// address and descriptor widths, header field positions, FIFO sizing,
// retry timer constants and the fetch FSM state codes
`default_nettype none

package desc_fetch_pkg;

  localparam int ADDR_WIDTH       = 32;             // memory byte address
  localparam int DESC_WIDTH       = 128;            // one descriptor is a single read beat
  localparam int DESC_BYTES       = DESC_WIDTH / 8; // address step between descriptors, 16 bytes
  localparam int FIFO_DEPTH_LOG2  = 4;              // both FIFOs hold 16 entries
  localparam int FIFO_ALMOST_FULL = 8;              // descriptor FIFO level that stops new reads
  localparam int TIMEOUT_WIDTH    = 16;

  // the retry timer starts above zero to cover the pipeline and state hops
  localparam logic [TIMEOUT_WIDTH-1:0] RETRY_START = 16'd6;

  // ******************************************************************
  // descriptor header fields
  // ******************************************************************
  localparam int FMT_LSB     = 0;  // format byte, bit 0 is first of block and bit 1 is last
  localparam int BSIZE_LSB   = 8;  // number of descriptors that follow the first one
  localparam int BSIZE_WIDTH = 8;
  localparam int OWNED_BIT   = 16; // set when the descriptor belongs to hardware
  localparam int NEXT_LSB    = 96; // next-block address in the top word

  // ******************************************************************
  // fetch FSM state codes
  // ******************************************************************
  localparam int STATE_WIDTH = 3;
  localparam logic [STATE_WIDTH-1:0] ST_IDLE         = 3'd0; // disabled or just flushed
  localparam logic [STATE_WIDTH-1:0] ST_LOAD_COUNTER = 3'd1; // one cycle to load the address
  localparam logic [STATE_WIDTH-1:0] ST_LOAD_FIRST   = 3'd2; // one read for the block header
  localparam logic [STATE_WIDTH-1:0] ST_LOAD_REST    = 3'd3; // reads for the rest of the block
  localparam logic [STATE_WIDTH-1:0] ST_RETRY_WAIT   = 3'd4; // timing out before a refetch
  localparam logic [STATE_WIDTH-1:0] ST_WAIT_RELOAD  = 3'd5; // end of chain, host must reload

endpackage

`default_nettype wire

//--- verilog/addr_ctrl_if.sv
// address control bus between the fetch sequencer and the address generator
// the sequencer steers the address counters, the generator returns the address
`timescale 1ns/1ps
`default_nettype none

interface addr_ctrl_if
  import desc_fetch_pkg::*;
();

  logic                  load_location; // strobe that copies the next-block address in
  logic                  store_next;    // capture the next field of a valid first descriptor
  logic [ADDR_WIDTH-1:0] next_location; // next field straight from the read data
  logic                  increment;     // step the running address by one descriptor
  logic [ADDR_WIDTH-1:0] address;       // running read address

  modport sequencer (
    output load_location, store_next, next_location, increment,
    input  address
  );

  modport address_gen (
    input  load_location, store_next, next_location, increment,
    output address
  );

endinterface

`default_nettype wire

//--- verilog/sync_fifo.sv
// synchronous FIFO with a show-ahead output
// the head entry is on q whenever empty is low; almost-full rises at a fixed level
// and clear empties the FIFO in one cycle
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
  import desc_fetch_pkg::*;
#(
  parameter int WIDTH      = DESC_WIDTH,
  parameter int DEPTH_LOG2 = FIFO_DEPTH_LOG2
)
(
  input  wire              clk,
  input  wire              clear,
  input  wire              write,
  input  wire  [WIDTH-1:0] data,
  input  wire              read,
  output logic [WIDTH-1:0] q,
  output logic             empty,
  output logic             almost_full
);

  logic [WIDTH-1:0]      mem [2**DEPTH_LOG2];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;      // one bit wider than the pointers to tell full from empty
  logic                  full;
  logic                  do_write;
  logic                  do_read;

  assign full     = (count == (DEPTH_LOG2+1)'(2**DEPTH_LOG2));
  assign do_read  = read & ~empty;
  assign do_write = write & (~full | do_read);  // a read frees the slot in the same cycle

  always_ff @(posedge clk)
  begin
    if (do_write)
    begin
      mem[wr_ptr] <= data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      wr_ptr <= wr_ptr + DEPTH_LOG2'(do_write);
      rd_ptr <= rd_ptr + DEPTH_LOG2'(do_read);
      case ({do_write, do_read})
        2'b10:   count <= count + (DEPTH_LOG2+1)'(1);
        2'b01:   count <= count - (DEPTH_LOG2+1)'(1);
        default: count <= count;
      endcase
    end
  end

  assign q           = mem[rd_ptr];  // asynchronous read gives the show-ahead head
  assign empty       = (count == '0);
  assign almost_full = (count >= (DEPTH_LOG2+1)'(FIFO_ALMOST_FULL));

endmodule

`default_nettype wire

//--- verilog/fetch_address_gen.sv
// fetch address generator
// keeps the next-block address and the running read address that walks a block
`timescale 1ns/1ps
`default_nettype none

module fetch_address_gen
  import desc_fetch_pkg::*;
(
  input  wire                   clk,
  input  wire  [ADDR_WIDTH-1:0] new_location,      // first block location from the host
  input  wire                   load_new_location,
  addr_ctrl_if.address_gen      ctrl
);

  logic [ADDR_WIDTH-1:0] next_address;
  logic [ADDR_WIDTH-1:0] address_counter;

  // host load overrides a header that happens to return in the same cycle
  always_ff @(posedge clk)
  begin
    if (load_new_location)
    begin
      next_address <= new_location;
    end
    else if (ctrl.store_next)
    begin
      next_address <= ctrl.next_location;
    end
  end

  // reloaded once per block in load-counter, stepped per descriptor after that
  always_ff @(posedge clk)
  begin
    if (ctrl.load_location)
    begin
      address_counter <= next_address;
    end
    else if (ctrl.increment)
    begin
      address_counter <= address_counter + ADDR_WIDTH'(DESC_BYTES);
    end
  end

  assign ctrl.address = address_counter;  // read address and block FIFO input

endmodule

`default_nettype wire

//--- verilog/fetch_sequencer.sv
// fetch sequencer
// walks one block at a time: one read for the header descriptor, then one read
// per remaining descriptor; tracks reads in flight, throttles on a full buffer
// and retries or parks at the end of the descriptor chain
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer
  import desc_fetch_pkg::*;
(
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        enable_fetch,
  input  wire                        flush,
  input  wire                        load_new_location,
  input  wire                        enable_retry,
  input  wire  [TIMEOUT_WIDTH-1:0]   retry_timeout,
  input  wire                        m_waitrequest,
  input  wire                        m_readdatavalid,
  input  wire  [DESC_WIDTH-1:0]      m_readdata,
  input  wire                        desc_almost_full,
  output logic                       m_read,
  output logic                       desc_write,
  output logic                       block_write,
  output logic [FIFO_DEPTH_LOG2-1:0] outstanding_reads,
  output logic                       fetch_idle,
  addr_ctrl_if.sequencer             ctrl
);

  logic [STATE_WIDTH-1:0]     state;
  logic [BSIZE_WIDTH-1:0]     block_counter;   // descriptors of the block still to be read
  logic [BSIZE_WIDTH-1:0]     block_size;
  logic [FIFO_DEPTH_LOG2-1:0] reads_counter;
  logic [TIMEOUT_WIDTH-1:0]   retry_timer;
  logic read_active;
  logic set_read_active;
  logic clear_read_active;
  logic first_read_complete;                   // load-first has posted its single read
  logic read_accepted;
  logic first_return;
  logic first_valid;
  logic end_of_chain;
  logic last_read;
  logic too_many_reads;
  logic trigger_refetch;
  logic trigger_refetch_d1;

  // ******************************************************************
  // header decode of the returning word
  // ******************************************************************
  assign block_size    = m_readdata[BSIZE_LSB +: BSIZE_WIDTH];
  assign read_accepted = m_read & ~m_waitrequest;

  // reads return in order and the header read is always the youngest one, so
  // it is the beat that arrives while exactly one read is in flight
  assign first_return = (state == ST_LOAD_FIRST) & m_readdatavalid & first_read_complete &
                        (reads_counter == FIFO_DEPTH_LOG2'(1));
  assign first_valid  = first_return & m_readdata[OWNED_BIT] & m_readdata[FMT_LSB];
  assign end_of_chain = first_return & ~first_valid;  // host has not handed this block over yet
  assign last_read    = (state == ST_LOAD_REST) & read_accepted &
                        (block_counter == BSIZE_WIDTH'(1));

  always_ff @(posedge clk)
  begin
    if (reset | flush | ~enable_fetch)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (~read_active)            // let a read left over from a disable finish first
          begin
            state <= ST_LOAD_COUNTER;
          end
        ST_LOAD_COUNTER:
          state <= ST_LOAD_FIRST;
        ST_LOAD_FIRST:
          if (end_of_chain)
          begin
            state <= enable_retry ? ST_RETRY_WAIT : ST_WAIT_RELOAD;
          end
          else if (first_valid)
          begin
            // a block size of zero means the header was the whole block
            state <= (block_size == '0) ? ST_LOAD_COUNTER : ST_LOAD_REST;
          end
        ST_LOAD_REST:
          if (last_read)
          begin
            state <= ST_LOAD_COUNTER;  // next block address was stored with the header
          end
        ST_RETRY_WAIT:
          if (trigger_refetch_d1)
          begin
            state <= ST_LOAD_COUNTER;
          end
        ST_WAIT_RELOAD:
          if (load_new_location)
          begin
            state <= ST_LOAD_COUNTER;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      block_counter <= '0;
    end
    else if (first_valid)
    begin
      block_counter <= block_size;
    end
    else if ((state == ST_LOAD_REST) & read_accepted)
    begin
      block_counter <= block_counter - BSIZE_WIDTH'(1);
    end
  end

  // ******************************************************************
  // read issue and throttling
  // ******************************************************************
  assign too_many_reads = reads_counter[FIFO_DEPTH_LOG2-1] | desc_almost_full;

  // raising the flag in load-counter puts the header read out on the first
  // load-first cycle
  assign set_read_active = ((state == ST_LOAD_COUNTER) |
                            ((state == ST_LOAD_FIRST) & ~first_read_complete) |
                            (state == ST_LOAD_REST)) & ~too_many_reads;
  // a posted read cannot be withdrawn, so every drop waits for an accept
  assign clear_read_active = read_accepted &
                             ((state != ST_LOAD_REST) | too_many_reads | last_read);

  always_ff @(posedge clk)
  begin
    if (reset | clear_read_active)     // clearing wins over setting
    begin
      read_active <= 1'b0;
    end
    else if (set_read_active)
    begin
      read_active <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset | (state == ST_LOAD_COUNTER))
    begin
      first_read_complete <= 1'b0;
    end
    else if ((state == ST_LOAD_FIRST) & read_accepted)
    begin
      first_read_complete <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      reads_counter <= '0;
    end
    else
    begin
      case ({read_accepted, m_readdatavalid})
        2'b10:   reads_counter <= reads_counter + FIFO_DEPTH_LOG2'(1);
        2'b01:   reads_counter <= reads_counter - FIFO_DEPTH_LOG2'(1);
        default: reads_counter <= reads_counter;  // none or one in and one out
      endcase
    end
  end

  // ******************************************************************
  // retry timer
  // ******************************************************************
  always_ff @(posedge clk)
  begin
    if (reset | (state != ST_RETRY_WAIT))
    begin
      retry_timer <= RETRY_START;
    end
    else
    begin
      retry_timer <= retry_timer + TIMEOUT_WIDTH'(1);
    end
  end

  // greater or equal so that a timeout below the start value still fires
  assign trigger_refetch = (state == ST_RETRY_WAIT) & (retry_timer >= retry_timeout);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      trigger_refetch_d1 <= 1'b0;
    end
    else
    begin
      trigger_refetch_d1 <= trigger_refetch;
    end
  end

  assign m_read            = read_active;
  assign desc_write        = m_readdatavalid & m_readdata[OWNED_BIT];  // only owned words are kept
  assign block_write       = first_valid;
  assign outstanding_reads = reads_counter;
  assign fetch_idle        = ~enable_fetch | (state == ST_WAIT_RELOAD);

  assign ctrl.load_location = (state == ST_LOAD_COUNTER);
  assign ctrl.store_next    = first_valid;  // an unowned header leaves the old address for a retry
  assign ctrl.next_location = m_readdata[NEXT_LSB +: ADDR_WIDTH];
  assign ctrl.increment     = first_valid | ((state == ST_LOAD_REST) & read_accepted);

endmodule

`default_nettype wire

//--- verilog/desc_fetch_top.sv
// descriptor fetch engine for a scatter-gather DMA
// walks linked blocks of 128-bit descriptors in memory with single-beat reads,
// buffers owned descriptors in a FIFO for the descriptor stream and queues the
// start address of every valid block on the block stream
`timescale 1ns/1ps
`default_nettype none

module desc_fetch_top
  import desc_fetch_pkg::*;
(
  input  wire                        clk,
  input  wire                        reset,

  // memory read port
  output logic [ADDR_WIDTH-1:0]      m_address,
  output logic                       m_read,
  input  wire                        m_waitrequest,
  input  wire  [DESC_WIDTH-1:0]      m_readdata,
  input  wire                        m_readdatavalid,

  // descriptor stream
  output logic [DESC_WIDTH-1:0]      descriptor,
  output logic                       descriptor_valid,
  input  wire                        descriptor_ready,

  // block start address stream
  output logic [ADDR_WIDTH-1:0]      block_address,
  output logic                       block_address_valid,
  input  wire                        block_address_ready,

  // host control
  input  wire                        enable_fetch,      // disable, flush and drain before a new location
  input  wire                        flush,
  input  wire  [ADDR_WIDTH-1:0]      new_location,
  input  wire                        load_new_location,
  input  wire  [TIMEOUT_WIDTH-1:0]   retry_timeout,     // cycles before an unowned block is refetched
  input  wire                        enable_retry,
  output logic [FIFO_DEPTH_LOG2-1:0] outstanding_reads,
  output logic                       fetch_idle
);

  logic desc_write;
  logic desc_empty;
  logic desc_almost_full;
  logic block_write;
  logic block_empty;
  logic fifo_clear;

  addr_ctrl_if ctrl_bus ();

  assign fifo_clear          = reset | flush;         // flush drops everything buffered so far
  assign m_address           = ctrl_bus.address;
  assign descriptor_valid    = ~desc_empty;
  assign block_address_valid = ~block_empty;

  fetch_sequencer u_sequencer (
    .clk               (clk),
    .reset             (reset),
    .enable_fetch      (enable_fetch),
    .flush             (flush),
    .load_new_location (load_new_location),
    .enable_retry      (enable_retry),
    .retry_timeout     (retry_timeout),
    .m_waitrequest     (m_waitrequest),
    .m_readdatavalid   (m_readdatavalid),
    .m_readdata        (m_readdata),
    .desc_almost_full  (desc_almost_full),
    .m_read            (m_read),
    .desc_write        (desc_write),
    .block_write       (block_write),
    .outstanding_reads (outstanding_reads),
    .fetch_idle        (fetch_idle),
    .ctrl              (ctrl_bus.sequencer)
  );

  fetch_address_gen u_address_gen (
    .clk               (clk),
    .new_location      (new_location),
    .load_new_location (load_new_location),
    .ctrl              (ctrl_bus.address_gen)
  );

  // owned descriptors straight off the read data bus
  sync_fifo #(.WIDTH(DESC_WIDTH), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) desc_fifo (
    .clk         (clk),
    .clear       (fifo_clear),
    .write       (desc_write),
    .data        (m_readdata),
    .read        (descriptor_valid & descriptor_ready),
    .q           (descriptor),
    .empty       (desc_empty),
    .almost_full (desc_almost_full)
  );

  // block start addresses, written before the address counter moves on
  sync_fifo #(.WIDTH(ADDR_WIDTH), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) block_fifo (
    .clk         (clk),
    .clear       (fifo_clear),
    .write       (block_write),
    .data        (ctrl_bus.address),
    .read        (block_address_valid & block_address_ready),
    .q           (block_address),
    .empty       (block_empty),
    .almost_full ()
  );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// testbench clock and reset source
// 4 ns clock, reset held high for the first two rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);

  initial clk = 1'b0;
  always #2 clk = ~clk;  // half of the 4 ns period

  initial
  begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- test/desc_fetch_assert.sv
// protocol assertions for the descriptor fetch engine
// read port hold under waitrequest, reads in flight bound, stream valids after reset
`timescale 1ns/1ps
`default_nettype none

module desc_fetch_assert
  import desc_fetch_pkg::*;
(
  input wire                       clk,
  input wire                       reset,
  input wire                       m_read,
  input wire                       m_waitrequest,
  input wire [ADDR_WIDTH-1:0]      m_address,
  input wire [FIFO_DEPTH_LOG2-1:0] outstanding_reads,
  input wire                       descriptor_valid,
  input wire                       block_address_valid
);

  // a stalled read keeps its address and stays posted
  read_hold: assert property (@(posedge clk) disable iff (reset)
    (m_read & m_waitrequest) |=> (m_read & $stable(m_address)))
    else $error("read dropped or address moved under waitrequest");

  // throttling at half the FIFO acts one read late, so one more read can slip out
  reads_bound: assert property (@(posedge clk) disable iff (reset)
    int'(outstanding_reads) <= 2**(FIFO_DEPTH_LOG2-1) + 1)
    else $error("too many reads in flight");

  valid_after_reset: assert property (@(posedge clk)
    reset |=> (~descriptor_valid & ~block_address_valid))
    else $error("stream valid high after reset");

endmodule

`default_nettype wire

//--- test/desc_fetch_tb.sv
// testbench for the descriptor fetch engine
// a memory model with random waitrequest and latency serves descriptor blocks,
// directed tests walk single blocks, chains, reload, retry, back-pressure and flush
`timescale 1ns/1ps
`default_nettype none

module desc_fetch_tb
  import desc_fetch_pkg::*;
;

  logic                       clk;
  logic                       reset;
  logic [ADDR_WIDTH-1:0]      m_address;
  logic                       m_read;
  logic                       m_waitrequest;
  logic [DESC_WIDTH-1:0]      m_readdata;
  logic                       m_readdatavalid;
  logic [DESC_WIDTH-1:0]      descriptor;
  logic                       descriptor_valid;
  logic                       descriptor_ready;
  logic [ADDR_WIDTH-1:0]      block_address;
  logic                       block_address_valid;
  logic                       block_address_ready;
  logic                       enable_fetch;
  logic                       flush;
  logic [ADDR_WIDTH-1:0]      new_location;
  logic                       load_new_location;
  logic [TIMEOUT_WIDTH-1:0]   retry_timeout;
  logic                       enable_retry;
  logic [FIFO_DEPTH_LOG2-1:0] outstanding_reads;
  logic                       fetch_idle;

  logic [DESC_WIDTH-1:0] mem [logic [ADDR_WIDTH-1:0]];  // sparse descriptor memory
  logic [DESC_WIDTH-1:0] pend_data[$];                  // accepted reads waiting to return
  int                    pend_due[$];
  int                    cycle;
  int                    ready_mode;                    // 0 ready, 1 held low, 2 random
  logic [DESC_WIDTH-1:0] exp_desc[$];
  logic [DESC_WIDTH-1:0] rx_desc[$];
  logic [ADDR_WIDTH-1:0] exp_block[$];
  logic [ADDR_WIDTH-1:0] rx_block[$];

  tb_clock u_clock (.clk(clk), .reset(reset));

  desc_fetch_top u_dut (.*);

  bind desc_fetch_top desc_fetch_assert u_assert (
    .clk(clk), .reset(reset), .m_read(m_read), .m_waitrequest(m_waitrequest),
    .m_address(m_address), .outstanding_reads(outstanding_reads),
    .descriptor_valid(descriptor_valid), .block_address_valid(block_address_valid)
  );

  // ********************************************************************
  // memory model and stream monitors
  // ********************************************************************
  always @(posedge clk)
  begin
    cycle = cycle + 1;
    // reads still queued in memory plus the beat on the bus right now
    if (!reset)
      check("outstanding_reads", 128'(outstanding_reads),
            128'(pend_data.size() + int'(m_readdatavalid)));
    if (pend_data.size() > 0 && pend_due[0] <= cycle)
    begin
      m_readdata      <= pend_data.pop_front();
      m_readdatavalid <= 1'b1;
      void'(pend_due.pop_front());
    end
    else
    begin
      m_readdatavalid <= 1'b0;
    end
    if (!reset && m_read && !m_waitrequest)  // data is captured when the read is accepted
    begin
      pend_data.push_back(mem.exists(m_address) ? mem[m_address] : '0);
      pend_due.push_back(cycle + 1 + int'($urandom % 6));  // in order even if due earlier
    end
    m_waitrequest <= ($urandom % 4) == 0;
    case (ready_mode)
      0:       descriptor_ready <= 1'b1;
      1:       descriptor_ready <= 1'b0;
      default: descriptor_ready <= ($urandom % 2) == 1;
    endcase
  end

  always @(posedge clk)
  begin
    if (!reset && descriptor_valid && descriptor_ready)
      rx_desc.push_back(descriptor);
    if (!reset && block_address_valid && block_address_ready)
      rx_block.push_back(block_address);
  end

  // watchdog, 2000 cycles for each of the six tests
  initial
  begin
    repeat (6 * 2000) @(posedge clk);
    $display("timeout: the engine did not deliver the expected descriptors in time");
    $display("Result: FAILED");
    $fatal(1, "timeout");
  end

  // ********************************************************************
  // helpers
  // ********************************************************************
  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("error %s got %h expected %h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  function automatic logic [DESC_WIDTH-1:0] make_desc(input logic [7:0] fmt,
      input logic [7:0] bsize, input logic owned, input logic [31:0] next,
      input logic [31:0] tag);
    logic [DESC_WIDTH-1:0] d;
    d = '0;
    d[FMT_LSB +: 8]                 = fmt;
    d[BSIZE_LSB +: BSIZE_WIDTH]     = bsize;
    d[OWNED_BIT]                    = owned;
    d[63:32]                        = tag;   // opaque payload marks each descriptor
    d[95:64]                        = ~tag;
    d[NEXT_LSB +: ADDR_WIDTH]       = next;
    return d;
  endfunction

  // header plus n_rest owned descriptors, expected order follows memory order
  task automatic put_block(input logic [31:0] addr, input int n_rest, input logic [31:0] next);
    logic [7:0] fmt;
    fmt = (n_rest == 0) ? 8'h03 : 8'h01;
    mem[addr] = make_desc(fmt, 8'(n_rest), 1'b1, next, addr);
    exp_desc.push_back(mem[addr]);
    exp_block.push_back(addr);
    for (int i = 1; i <= n_rest; i++)
    begin
      fmt = (i == n_rest) ? 8'h02 : 8'h00;
      mem[addr + 32'(DESC_BYTES * i)] = make_desc(fmt, 8'h00, 1'b1, 32'h0,
                                                  addr + 32'(DESC_BYTES * i));
      exp_desc.push_back(mem[addr + 32'(DESC_BYTES * i)]);
    end
  endtask

  task automatic put_end(input logic [31:0] addr);
    mem[addr] = make_desc(8'h03, 8'h00, 1'b0, 32'h0, addr);  // header not handed over
  endtask

  task automatic clear_queues();
    exp_desc.delete();
    rx_desc.delete();
    exp_block.delete();
    rx_block.delete();
  endtask

  // disable and hold flush until every read in flight has come back
  task automatic flush_engine();
    enable_fetch <= 1'b0;
    flush        <= 1'b1;
    do
      @(posedge clk);
    while (outstanding_reads != '0 || m_read);
    @(posedge clk);
    flush <= 1'b0;
    @(posedge clk);
    clear_queues();
  endtask

  task automatic launch(input logic [31:0] loc);
    new_location      <= loc;
    load_new_location <= 1'b1;
    @(posedge clk);
    load_new_location <= 1'b0;
    enable_fetch      <= 1'b1;
  endtask

  // wait for everything expected, then let duplicates show up before counting
  task automatic expect_results();
    while (rx_desc.size() < exp_desc.size() || rx_block.size() < exp_block.size())
      @(posedge clk);
    repeat (30) @(posedge clk);
    check("descriptor count", 128'(rx_desc.size()), 128'(exp_desc.size()));
    check("block count", 128'(rx_block.size()), 128'(exp_block.size()));
    for (int i = 0; i < exp_desc.size(); i++)
      check("descriptor", rx_desc[i], exp_desc[i]);
    for (int i = 0; i < exp_block.size(); i++)
      check("block_address", 128'(rx_block[i]), 128'(exp_block[i]));
  endtask

  // ********************************************************************
  // directed tests
  // ********************************************************************
  task automatic single_block_test();
    flush_engine();
    put_block(32'h1000, 3, 32'h2000);
    put_end(32'h2000);
    launch(32'h1000);
    expect_results();
  endtask

  task automatic chain_test();
    flush_engine();
    put_block(32'h3000, 3, 32'h3100);
    put_block(32'h3100, 0, 32'h3200);
    put_end(32'h3200);
    launch(32'h3000);
    expect_results();
    // the unowned header is only a few reads behind the last block
    for (int i = 0; i < 100 && !fetch_idle; i++)
      @(posedge clk);
    check("fetch_idle", 128'(fetch_idle), 128'(1));
  endtask

  task automatic reload_test();
    clear_queues();  // engine parked waiting for the host
    put_block(32'h7000, 1, 32'h7100);
    put_end(32'h7100);
    new_location      <= 32'h7000;
    load_new_location <= 1'b1;
    @(posedge clk);
    load_new_location <= 1'b0;
    expect_results();
  endtask

  task automatic retry_test();
    flush_engine();
    enable_retry  <= 1'b1;
    retry_timeout <= 16'd20;
    put_block(32'h4000, 0, 32'h5000);
    mem[32'h5000] = make_desc(8'h03, 8'h00, 1'b0, 32'h6000, 32'h5000);
    put_end(32'h6000);
    launch(32'h4000);
    while (rx_desc.size() < 1)
      @(posedge clk);
    repeat (100) @(posedge clk);  // several refetches of the unowned header
    check("descriptor count", 128'(rx_desc.size()), 128'(1));
    mem[32'h5000] = make_desc(8'h03, 8'h00, 1'b1, 32'h6000, 32'h5000);
    exp_desc.push_back(mem[32'h5000]);
    exp_block.push_back(32'h5000);
    expect_results();
    enable_retry <= 1'b0;
  endtask

  task automatic backpressure_test();
    flush_engine();
    ready_mode <= 1;
    put_block(32'h8000, 11, 32'h9000);
    put_end(32'h9000);
    launch(32'h8000);
    repeat (200) @(posedge clk);
    check("descriptor count", 128'(rx_desc.size()), 128'(0));
    ready_mode <= 2;
    expect_results();
    ready_mode <= 0;
  endtask

  task automatic flush_test();
    flush_engine();
    put_block(32'ha000, 9, 32'hb000);
    put_end(32'hb000);
    launch(32'ha000);
    while (rx_desc.size() < 2)
      @(posedge clk);
    flush_engine();
    @(posedge clk);
    check("descriptor_valid", 128'(descriptor_valid), 128'(0));
    check("block_address_valid", 128'(block_address_valid), 128'(0));
    put_block(32'hc000, 2, 32'hd000);
    put_end(32'hd000);
    launch(32'hc000);
    expect_results();
  endtask

  initial
  begin
    void'($urandom(32'h43f1));
    cycle               = 0;
    ready_mode          = 0;
    m_waitrequest       = 1'b0;
    m_readdata          = '0;
    m_readdatavalid     = 1'b0;
    descriptor_ready    = 1'b1;
    block_address_ready = 1'b1;
    enable_fetch        = 1'b0;
    flush               = 1'b0;
    new_location        = '0;
    load_new_location   = 1'b0;
    retry_timeout       = '0;
    enable_retry        = 1'b0;
    @(posedge clk);
    while (reset)
      @(posedge clk);
    single_block_test();
    chain_test();
    reload_test();
    retry_test();
    backpressure_test();
    flush_test();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
verilog/desc_fetch_pkg.sv
verilog/addr_ctrl_if.sv
verilog/sync_fifo.sv
verilog/fetch_address_gen.sv
verilog/fetch_sequencer.sv
verilog/desc_fetch_top.sv
test/tb_clock.sv
test/desc_fetch_assert.sv
test/desc_fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the descriptor fetch testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f list.f --top-module desc_fetch_tb \
  -o desc_fetch_sim || exit 1
sim_out=$(./obj_dir/desc_fetch_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "^Result: PASSED$" && exit 0 || exit 1
